// File: hdl/cachePkg.sv
`default_nettype none

package cachePkg;

	////////////////////////////////////////////////////////////
	// bus and address field types
	////////////////////////////////////////////////////////////

	typedef logic [31:0] addrT;                 // byte address on both the cpu and dram side
	typedef logic [15:0] wordT;                 // one bus word
	typedef logic [18:0] tagT;                  // address bits 31 to 13 kept per line
	typedef logic [8:0]  indexT;                // address bits 12 to 4 pick the line
	typedef logic [2:0]  wordSelT;              // address bits 3 to 1 pick the word in a line

	localparam int TagLsb   = 13;               // lowest address bit of the tag field
	localparam int IndexLsb = 4;                // lowest address bit of the index field
	localparam int WordLsb  = 1;                // bit 0 is the byte within a word

	localparam int LineWords = 8;               // words fetched by one burst fill
	localparam int NumLines  = 512;             // lines in the direct mapped arrays

	////////////////////////////////////////////////////////////
	// controller states
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		invalidating,                           // sweep clearing every valid bit after reset
		idle,                                   // waiting for a cpu cycle aimed at dram
		checkHit,                               // tag and valid arrays answer for the cpu address
		cacheReadHold,                          // hit data given, waiting for the cpu to end
		fillRequest,                            // dram selected, waiting for the read cas edge
		casWait,                                // counting off the cas latency
		burstFill,                              // one dram word per clock written into the line
		fillDone,                               // line complete, word given to the cpu
		writeThrough                            // cpu write passed on to dram
	} cacheStateT;

endpackage

`default_nettype wire

// File: hdl/cacheRam.sv
`timescale 1ns/100ps
`default_nettype none

module cacheRam #(
	parameter type Payload = logic,                     // what one entry holds
	parameter int  Depth   = 512                        // number of entries
) (
	input  wire logic                         Clock,
	input  wire logic                         WriteEnable,  // active high, takes effect on the clock edge
	input  wire logic [$clog2(Depth) - 1:0]   WriteAddress,
	input  wire Payload                       WriteData,
	input  wire logic [$clog2(Depth) - 1:0]   ReadAddress,
	output Payload                            ReadData      // follows ReadAddress with no clock
);

	Payload store [Depth];                              // the array itself

	always_ff @(posedge Clock)
	begin
		if (WriteEnable)
			store[WriteAddress] <= WriteData;           // write lands on the rising edge
	end

	// read is combinational so a lookup answers in the same cycle the address arrives
	assign ReadData = store[ReadAddress];

endmodule

`default_nettype wire

// File: hdl/tagLookup.sv
`timescale 1ns/100ps
`default_nettype none

module tagLookup (
	input  wire logic           Clock,
	input  wire cachePkg::indexT Index,                 // line being looked up or written
	input  wire cachePkg::tagT   Tag,                   // upper bits of the cpu address
	input  wire logic           TagWrite,               // store Tag at Index on the next edge
	input  wire logic           ValidWrite,             // store ValidValue at Index on the next edge
	input  wire logic           ValidValue,             // 1 marks the line valid, 0 invalidates it
	output logic                Hit,                    // line valid and its tag matches
	output logic                LineValid               // valid bit of the line, tag ignored
);

	import cachePkg::*;

	tagT  storedTag;                                    // tag held for the addressed line
	logic storedValid;                                  // valid bit held for the addressed line

	////////////////////////////////////////////////////////////
	// tag and valid arrays share the index
	////////////////////////////////////////////////////////////

	cacheRam #(
		.Payload (tagT),
		.Depth   (NumLines)
	) tagRam (
		.Clock        (Clock),
		.WriteEnable  (TagWrite),
		.WriteAddress (Index),
		.WriteData    (Tag),
		.ReadAddress  (Index),
		.ReadData     (storedTag)
	);

	cacheRam #(
		.Payload (logic),
		.Depth   (NumLines)
	) validRam (
		.Clock        (Clock),
		.WriteEnable  (ValidWrite),
		.WriteAddress (Index),
		.WriteData    (ValidValue),
		.ReadAddress  (Index),
		.ReadData     (storedValid)
	);

	assign LineValid = storedValid;                     // the write path only needs this much
	assign Hit = storedValid && (storedTag == Tag);     // a stale tag in an invalid line never hits

endmodule

`default_nettype wire

// File: hdl/dramPort.sv
`timescale 1ns/100ps
`default_nettype none

module dramPort (
	input  wire cachePkg::addrT Address,                // cpu address
	input  wire cachePkg::wordT DataIn,                 // cpu write data
	input  wire logic          As_L,
	input  wire logic          We_L,
	input  wire logic          Uds_L,
	input  wire logic          Lds_L,
	input  wire logic          fillMode,                // line align the address for a burst fill
	input  wire logic          forceBothBytes,          // reads always fetch the whole word
	input  wire cachePkg::wordT CacheWord,              // word read out of the data array
	output cachePkg::addrT     DramAddress,
	output cachePkg::wordT     DramDataOut,
	output logic               DramAs_L,
	output logic               DramWe_L,
	output logic               DramUds_L,
	output logic               DramLds_L,
	output cachePkg::wordT     DataOut                  // data back to the cpu
);

	import cachePkg::*;

	addrT lineAddress;                                  // cpu address with the line offset cleared
	logic bothBytes;                                    // strobe override is in force

	// a fill always starts from word 0 of the line, the burst counter supplies the rest
	assign lineAddress = {Address[$bits(addrT) - 1:IndexLsb], {IndexLsb{1'b0}}};

	// writes keep the cpu's own byte strobes so a byte write stays a byte write
	assign bothBytes = forceBothBytes & We_L;

	always_comb
	begin
		DramAddress = fillMode ? lineAddress : Address; // writes go to the exact address
		DramDataOut = DataIn;                           // only meaningful during a write
		DramAs_L    = As_L;                             // cpu strobes pass straight through
		DramWe_L    = We_L;
		DramUds_L   = bothBytes ? 1'b0 : Uds_L;         // low means the upper byte is taken
		DramLds_L   = bothBytes ? 1'b0 : Lds_L;         // low means the lower byte is taken
	end

	assign DataOut = CacheWord;                         // cpu always reads through the cache

endmodule

`default_nettype wire

// File: hdl/cacheControl.sv
`timescale 1ns/100ps
`default_nettype none

module cacheControl #(
	parameter int CasLatency = 2                        // clocks from the read cas edge to word 0
) (
	input  wire logic             Clock,
	input  wire logic             Reset_L,
	input  wire logic             As_L,
	input  wire logic             We_L,
	input  wire logic             DramSelect,          // cpu is addressing the dram range
	input  wire cachePkg::addrT   Address,
	input  wire logic             Hit,
	input  wire logic             LineValid,
	input  wire logic             DramDtack_L,
	input  wire logic             DramCas_L,
	input  wire logic             DramRas_L,
	output logic                  Dtack_L,             // end of cycle back to the cpu
	output logic                  DramSelect_L,        // starts a dram controller cycle
	output cachePkg::indexT       Index,
	output cachePkg::wordSelT     WordSel,
	output logic                  TagWrite,
	output logic                  ValidWrite,
	output logic                  ValidValue,
	output logic                  DataWrite,
	output logic                  fillMode,
	output logic                  forceBothBytes
);

	import cachePkg::*;

	localparam int CountWidth = $clog2(NumLines);       // wide enough for the sweep, fill uses the low bits
	localparam int LatWidth   = $clog2(CasLatency + 1);

	cacheStateT state;                                  // current controller state
	cacheStateT nextState;
	logic [CountWidth - 1:0] burstCount;                // sweep line number or fill word number
	logic [LatWidth - 1:0] latencyCount;                // cas clocks still to wait
	logic burstClear;                                   // restart the burst counter
	logic burstStep;                                    // advance the burst counter
	logic latencyLoad;                                  // arm the latency counter
	logic cpuCycle;                                     // cpu strobe and select both active

	assign cpuCycle = !As_L && DramSelect;

	////////////////////////////////////////////////////////////
	// state and counter registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state        <= invalidating;               // every line is swept after reset
			burstCount   <= '0;
			latencyCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (burstClear)
				burstCount <= '0;
			else if (burstStep)
				burstCount <= burstCount + 1'b1;
			if (latencyLoad)
				latencyCount <= LatWidth'(CasLatency - 1); // casWait itself is the first clock
			else if (state == casWait)
				latencyCount <= latencyCount - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState      = state;                         // stay unless a branch below moves on
		Dtack_L        = 1'b1;
		DramSelect_L   = 1'b1;                          // dram is left alone on a hit
		Index          = Address[IndexLsb +: $bits(indexT)];
		WordSel        = Address[WordLsb +: $bits(wordSelT)];
		TagWrite       = 1'b0;
		ValidWrite     = 1'b0;
		ValidValue     = 1'b0;
		DataWrite      = 1'b0;
		fillMode       = 1'b0;
		forceBothBytes = 1'b0;
		burstClear     = 1'b0;
		burstStep      = 1'b0;
		latencyLoad    = 1'b0;

		case (state)
			invalidating:
			begin
				Index      = burstCount;                // counter walks the lines
				ValidWrite = 1'b1;                      // ValidValue stays 0
				burstStep  = 1'b1;
				if (burstCount == CountWidth'(NumLines - 1))
				begin
					burstClear = 1'b1;                  // leave the counter at 0 for the first fill
					nextState  = idle;
				end
			end
			idle:
			begin
				if (cpuCycle && We_L)
				begin
					forceBothBytes = 1'b1;              // whole word is fetched regardless of strobes
					nextState      = checkHit;
				end
				else if (cpuCycle)
				begin
					ValidWrite   = LineValid;           // drop the line rather than update it
					DramSelect_L = 1'b0;                // the write starts right away
					nextState    = writeThrough;
				end
			end
			checkHit:
			begin
				forceBothBytes = 1'b1;
				fillMode       = 1'b1;
				if (Hit)
				begin
					Dtack_L   = 1'b0;                   // array read is combinational so data is ready
					nextState = cacheReadHold;
				end
				else
				begin
					DramSelect_L = 1'b0;
					nextState    = fillRequest;
				end
			end
			cacheReadHold:
			begin
				forceBothBytes = 1'b1;
				fillMode       = 1'b1;
				Dtack_L        = 1'b0;                  // held until the cpu lets go of As_L
				if (As_L)
					nextState = idle;
			end
			fillRequest:
			begin
				forceBothBytes = 1'b1;
				fillMode       = 1'b1;
				DramSelect_L   = 1'b0;
				TagWrite       = 1'b1;                  // claim the line for this address
				ValidWrite     = 1'b1;
				ValidValue     = 1'b1;
				if (!DramCas_L && DramRas_L)            // cas without ras is a read, not a refresh
				begin
					latencyLoad = 1'b1;
					nextState   = casWait;
				end
			end
			casWait:
			begin
				forceBothBytes = 1'b1;
				fillMode       = 1'b1;
				DramSelect_L   = 1'b0;
				if (latencyCount == '0)
				begin
					burstClear = 1'b1;                  // word 0 arrives in the first burstFill clock
					nextState  = burstFill;
				end
			end
			burstFill:
			begin
				forceBothBytes = 1'b1;
				fillMode       = 1'b1;
				DramSelect_L   = 1'b0;
				WordSel        = burstCount[$bits(wordSelT) - 1:0];
				DataWrite      = 1'b1;                  // one dram word stored per clock
				burstStep      = 1'b1;
				if (burstCount == CountWidth'(LineWords - 1))
				begin
					burstClear = 1'b1;
					nextState  = fillDone;
				end
			end
			fillDone:
			begin
				forceBothBytes = 1'b1;
				fillMode       = 1'b1;
				Dtack_L        = 1'b0;                  // the word asked for is now in the line
				if (!cpuCycle)
					nextState = idle;
			end
			writeThrough:
			begin
				DramSelect_L = 1'b0;
				Dtack_L      = DramDtack_L;             // the cpu waits on the dram itself
				if (!cpuCycle)
					nextState = idle;
			end
			default:
				nextState = idle;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/m68kCache.sv
`timescale 1ns/100ps
`default_nettype none

module m68kCache #(
	parameter int CasLatency = 2                        // dram read latency in clocks
) (
	input  wire logic           Clock,
	input  wire logic           Reset_L,
	input  wire cachePkg::addrT Address,
	input  wire cachePkg::wordT DataIn,
	input  wire logic           As_L,
	input  wire logic           Uds_L,
	input  wire logic           Lds_L,
	input  wire logic           We_L,
	input  wire logic           DramSelect,
	output cachePkg::wordT      DataOut,
	output logic                Dtack_L,
	output cachePkg::addrT      DramAddress,
	output cachePkg::wordT      DramDataOut,
	output logic                DramSelect_L,
	output logic                DramAs_L,
	output logic                DramWe_L,
	output logic                DramUds_L,
	output logic                DramLds_L,
	input  wire cachePkg::wordT DramDataIn,
	input  wire logic           DramDtack_L,
	input  wire logic           DramCas_L,
	input  wire logic           DramRas_L
);

	import cachePkg::*;

	indexT   index;                                     // line chosen by the controller
	wordSelT wordSel;                                   // word within that line
	logic    tagWrite;
	logic    validWrite;
	logic    validValue;
	logic    dataWrite;
	logic    fillMode;
	logic    forceBothBytes;
	logic    hit;
	logic    lineValid;
	tagT     lookupTag;                                 // tag field of the cpu address
	wordT    cacheWord;                                 // data array output
	logic [$clog2(NumLines * LineWords) - 1:0] dataAddress;

	assign lookupTag   = Address[TagLsb +: $bits(tagT)];
	assign dataAddress = {index, wordSel};              // data array is lines times words deep

	cacheControl #(
		.CasLatency (CasLatency)
	) control (
		.Clock          (Clock),
		.Reset_L        (Reset_L),
		.As_L           (As_L),
		.We_L           (We_L),
		.DramSelect     (DramSelect),
		.Address        (Address),
		.Hit            (hit),
		.LineValid      (lineValid),
		.DramDtack_L    (DramDtack_L),
		.DramCas_L      (DramCas_L),
		.DramRas_L      (DramRas_L),
		.Dtack_L        (Dtack_L),
		.DramSelect_L   (DramSelect_L),
		.Index          (index),
		.WordSel        (wordSel),
		.TagWrite       (tagWrite),
		.ValidWrite     (validWrite),
		.ValidValue     (validValue),
		.DataWrite      (dataWrite),
		.fillMode       (fillMode),
		.forceBothBytes (forceBothBytes)
	);

	tagLookup lookup (
		.Clock      (Clock),
		.Index      (index),
		.Tag        (lookupTag),
		.TagWrite   (tagWrite),
		.ValidWrite (validWrite),
		.ValidValue (validValue),
		.Hit        (hit),
		.LineValid  (lineValid)
	);

	cacheRam #(
		.Payload (wordT),
		.Depth   (NumLines * LineWords)
	) dataRam (
		.Clock        (Clock),
		.WriteEnable  (dataWrite),
		.WriteAddress (dataAddress),
		.WriteData    (DramDataIn),                     // only filled from dram, never from the cpu
		.ReadAddress  (dataAddress),
		.ReadData     (cacheWord)
	);

	dramPort port (
		.Address        (Address),
		.DataIn         (DataIn),
		.As_L           (As_L),
		.We_L           (We_L),
		.Uds_L          (Uds_L),
		.Lds_L          (Lds_L),
		.fillMode       (fillMode),
		.forceBothBytes (forceBothBytes),
		.CacheWord      (cacheWord),
		.DramAddress    (DramAddress),
		.DramDataOut    (DramDataOut),
		.DramAs_L       (DramAs_L),
		.DramWe_L       (DramWe_L),
		.DramUds_L      (DramUds_L),
		.DramLds_L      (DramLds_L),
		.DataOut        (DataOut)
	);

endmodule

`default_nettype wire

// File: dv/m68kCache_sva.sv
`timescale 1ns/100ps
`default_nettype none

module m68kCacheSva (
	input  wire logic           Clock,
	input  wire logic           Reset_L,
	input  wire logic           Dtack_L,
	input  wire cachePkg::addrT DramAddress,
	input  wire logic           DramSelect_L,
	input  wire logic           DramWe_L,
	input  wire logic           DramUds_L,
	input  wire logic           DramLds_L,
	input  wire logic           DramDtack_L
);

	int violations = 0;                                 // read back by the testbench at the end

	////////////////////////////////////////////////////////////
	// reset and dram read cycles
	////////////////////////////////////////////////////////////

	quietInReset: assert property (@(posedge Clock)
		!Reset_L |-> (Dtack_L && DramSelect_L))         // neither side is touched while in reset
	else
	begin
		$error("Dtack_L or DramSelect_L low during reset");
		violations++;
	end

	fillAligned: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSelect_L && DramWe_L) |-> (DramAddress[3:0] == 4'h0)) // a fill starts at word 0
	else
	begin
		$error("fill address %h is not line aligned", DramAddress);
		violations++;
	end

	readBothBytes: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSelect_L && DramWe_L) |-> (!DramUds_L && !DramLds_L)) // byte reads still fill words
	else
	begin
		$error("dram read without both byte strobes low");
		violations++;
	end

	////////////////////////////////////////////////////////////
	// write through
	////////////////////////////////////////////////////////////

	dtackFollowsDram: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSelect_L && !DramWe_L && !Dtack_L) |-> !DramDtack_L) // cpu never ends a write early
	else
	begin
		$error("Dtack_L low on a write before DramDtack_L");
		violations++;
	end

endmodule

`default_nettype wire

// File: dv/m68kCacheTb.sv
`timescale 1ns/100ps
`default_nettype none

module m68kCacheTb;

	import cachePkg::*;

	localparam int CasLatency     = 2;                  // dram read latency given to the dut
	localparam int RasDelay       = 2;                  // model clocks from select to the cas edge
	localparam int WriteDelay     = 3;                  // model clocks from select to its dtack
	localparam int DtackTimeout   = 64;                 // clocks allowed for one cpu cycle
	localparam int ReleaseTimeout = 16;                 // clocks allowed for a strobe to go away
	localparam logic [31:0] LfsrSeed = 32'd95508;

	logic Clock = 1'b0;
	logic Reset_L;
	addrT Address;
	wordT DataIn;
	logic As_L;
	logic Uds_L;
	logic Lds_L;
	logic We_L;
	logic DramSelect;                                   // cpu address decodes to dram
	wordT DataOut;
	logic Dtack_L;
	addrT DramAddress;
	wordT DramDataOut;
	logic DramSelect_L;
	logic DramAs_L;
	logic DramWe_L;
	logic DramUds_L;
	logic DramLds_L;
	wordT DramDataIn;
	logic DramDtack_L;
	logic DramCas_L;
	logic DramRas_L;

	logic [31:0] lfsr = LfsrSeed;
	wordT dramMem [addrT];                              // words the model dram has been given
	wordT cpuWritten [addrT];                           // data the cpu has written
	int errorCount = 0;
	int timeoutCount = 0;

	m68kCache #(
		.CasLatency (CasLatency)
	) u_m68kCache (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.Address      (Address),
		.DataIn       (DataIn),
		.As_L         (As_L),
		.Uds_L        (Uds_L),
		.Lds_L        (Lds_L),
		.We_L         (We_L),
		.DramSelect   (DramSelect),
		.DataOut      (DataOut),
		.Dtack_L      (Dtack_L),
		.DramAddress  (DramAddress),
		.DramDataOut  (DramDataOut),
		.DramSelect_L (DramSelect_L),
		.DramAs_L     (DramAs_L),
		.DramWe_L     (DramWe_L),
		.DramUds_L    (DramUds_L),
		.DramLds_L    (DramLds_L),
		.DramDataIn   (DramDataIn),
		.DramDtack_L  (DramDtack_L),
		.DramCas_L    (DramCas_L),
		.DramRas_L    (DramRas_L)
	);

	bind m68kCache m68kCacheSva protocolChecks (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.Dtack_L      (Dtack_L),
		.DramAddress  (DramAddress),
		.DramSelect_L (DramSelect_L),
		.DramWe_L     (DramWe_L),
		.DramUds_L    (DramUds_L),
		.DramLds_L    (DramLds_L),
		.DramDtack_L  (DramDtack_L)
	);

	always #5 Clock = ~Clock;                           // 10 ns period

	////////////////////////////////////////////////////////////
	// random numbers and expected data
	////////////////////////////////////////////////////////////

	function automatic logic lfsrBit();
		logic feedback;
		feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps of x^32 + x^22 + x^2 + x + 1
		lfsr = {lfsr[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [31:0] randomBits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsrBit()};           // one step for every bit taken
		return value;
	endfunction

	function automatic wordT modelWord(addrT byteAddress);
		if (dramMem.exists(byteAddress))
			return dramMem[byteAddress];
		return byteAddress[16:1] ^ 16'h5A5A;            // dram starts with its address pattern
	endfunction

	function automatic wordT expectedWord(addrT byteAddress);
		if (cpuWritten.exists(byteAddress))
			return cpuWritten[byteAddress];
		return byteAddress[16:1] ^ 16'h5A5A;
	endfunction

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] want);
		assert (actual === want)
		else
		begin
			$display("Error: %s is %h, expected %h", name, actual, want);
			errorCount++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// dram controller model
	////////////////////////////////////////////////////////////

	task automatic waitDramRelease();
		int waited;
		waited = 0;
		do
		begin
			@(posedge Clock);
			waited++;
		end
		while (!DramSelect_L && waited < ReleaseTimeout);
		if (!DramSelect_L)
		begin
			$display("timed out waiting for the cache to raise DramSelect_L");
			timeoutCount++;
		end
	endtask

	task automatic serveRead(addrT lineAddress);
		repeat (RasDelay) @(posedge Clock);
		#1;
		DramRas_L = 1'b1;                               // cas with ras high opens a read
		DramCas_L = 1'b0;
		@(posedge Clock);                               // the cache sees the cas edge here
		#1;
		DramRas_L = 1'b0;
		DramCas_L = 1'b1;
		repeat (CasLatency) @(posedge Clock);
		for (int k = 0; k < LineWords; k++)
		begin
			#1;
			DramDataIn = modelWord(lineAddress + addrT'(2 * k)); // one word per clock
			@(posedge Clock);
		end
		waitDramRelease();
	endtask

	task automatic serveWrite(addrT byteAddress, wordT data);
		dramMem[byteAddress] = data;
		repeat (WriteDelay) @(posedge Clock);
		#1;
		DramDtack_L = 1'b0;
		waitDramRelease();                              // dtack held until the cache lets go
		#1;
		DramDtack_L = 1'b1;
	endtask

	initial
	begin
		forever
		begin
			@(posedge Clock);
			if (Reset_L && !DramSelect_L)
			begin
				if (DramWe_L)
					serveRead(DramAddress);
				else
					serveWrite(DramAddress, DramDataOut);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// cpu bus cycles
	////////////////////////////////////////////////////////////

	task automatic waitForDtack(output logic sawDram);
		int waited;
		sawDram = 1'b0;
		waited = 0;
		do
		begin
			@(posedge Clock);
			if (!DramSelect_L)
				sawDram = 1'b1;                         // the dram was started during this cycle
			waited++;
		end
		while (Dtack_L && waited < DtackTimeout);
		if (Dtack_L)
		begin
			$display("timed out waiting for Dtack_L at address %h", Address);
			timeoutCount++;
		end
	endtask

	task automatic endCycle();
		int waited;
		#1;
		As_L       = 1'b1;                              // We_L and strobes stay for now
		DramSelect = 1'b0;
		waited = 0;
		do
		begin
			@(posedge Clock);
			waited++;
		end
		while (!Dtack_L && waited < ReleaseTimeout);
		if (!Dtack_L)
		begin
			$display("timed out waiting for Dtack_L to go high after the cycle");
			timeoutCount++;
		end
	endtask

	task automatic cpuRead(addrT byteAddress, logic expectMiss);
		logic sawDram;
		logic upperByte;
		upperByte = lfsrBit();                          // a byte read must still fill whole words
		@(posedge Clock);
		#1;
		Address    = byteAddress;
		We_L       = 1'b1;
		Uds_L      = !upperByte;
		Lds_L      = upperByte;
		DramSelect = 1'b1;
		As_L       = 1'b0;
		waitForDtack(sawDram);
		checkValue("DramSelect_L activity", sawDram, expectMiss);
		checkValue("DataOut", DataOut, expectedWord(byteAddress));
		endCycle();
	endtask

	task automatic cpuWrite(addrT byteAddress, wordT data);
		logic sawDram;
		@(posedge Clock);
		#1;
		Address    = byteAddress;
		DataIn     = data;
		We_L       = 1'b0;
		Uds_L      = 1'b0;
		Lds_L      = 1'b0;
		DramSelect = 1'b1;
		As_L       = 1'b0;
		cpuWritten[byteAddress] = data;                 // every write lands in dram
		waitForDtack(sawDram);
		checkValue("DramSelect_L activity", sawDram, 1'b1);
		checkValue("DramAddress", DramAddress, byteAddress);
		checkValue("DramDataOut", DramDataOut, data);
		checkValue("DramAs_L", DramAs_L, 1'b0);         // address strobe still held by the cpu
		endCycle();
	endtask

	initial
	begin
		addrT first;
		addrT second;
		addrT other;
		wordT data;
		Reset_L     = 1'b0;
		Address     = '0;
		DataIn      = '0;
		As_L        = 1'b1;
		Uds_L       = 1'b1;
		Lds_L       = 1'b1;
		We_L        = 1'b1;
		DramSelect  = 1'b0;
		DramDataIn  = '0;
		DramDtack_L = 1'b1;
		DramCas_L   = 1'b1;
		DramRas_L   = 1'b0;
		repeat (2) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
		for (int c = 0; c < NumLines + 8; c++)          // sweep runs with both sides left alone
		begin
			@(posedge Clock);
			checkValue("Dtack_L", Dtack_L, 1'b1);
			checkValue("DramSelect_L", DramSelect_L, 1'b1);
		end
		for (int n = 0; n < 4; n++)
		begin
			first  = randomBits(31) << 1;               // word aligned
			second = {first[31:4], 4'h0} | (randomBits(3) << 1);
			cpuRead(first, 1'b1);                       // cold line misses
			cpuRead(second, 1'b0);                      // same line now hits
			cpuRead(first, 1'b0);
			data = wordT'(randomBits(16));
			cpuWrite(second, data);                     // drops the cached line
			cpuRead(second, 1'b1);
			cpuRead(first, 1'b0);
			other = randomBits(31) << 1;
			data  = wordT'(randomBits(16));
			cpuWrite(other, data);                      // write to a line that was never filled
			cpuRead(other, 1'b1);
		end
		$display("errors %0d, timeouts %0d, assertion failures %0d",
			errorCount, timeoutCount, u_m68kCache.protocolChecks.violations);
		if (errorCount == 0 && timeoutCount == 0 && u_m68kCache.protocolChecks.violations == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: m68kCache.f
hdl/cachePkg.sv
hdl/cacheRam.sv
hdl/tagLookup.sv
hdl/dramPort.sv
hdl/cacheControl.sv
hdl/m68kCache.sv
dv/m68kCache_sva.sv
dv/m68kCacheTb.sv

// File: run.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module m68kCacheTb \
	-f m68kCache.f -o m68kCacheSim > build.log 2>&1
then
	echo "verilator build failed, see build.log"
	exit 1
fi

if ! ./obj_dir/m68kCacheSim +verilator+error+limit+100 > sim.log 2>&1
then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi

cat sim.log
if grep -qx "sim passed" sim.log
then
	exit 0
fi
exit 1
